// ==== rtl/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // Bus and memory widths
    localparam int addr_w    = 64;
    localparam int data_w    = 64;
    localparam int word_w    = 32;
    localparam int mem_words = 3072;

    // ROM and RAM windows share one physical RAM
    localparam logic [addr_w-1:0] rom_base = 64'h0000_0000_0000_0000;
    localparam logic [addr_w-1:0] rom_size = 64'h0000_0000_0000_1000;
    localparam logic [addr_w-1:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [addr_w-1:0] ram_size = 64'h0000_0000_0000_2000;

    // Single-word peripheral registers
    localparam logic [addr_w-1:0] key_addr     = 64'h0000_0000_0000_8000;
    localparam logic [addr_w-1:0] uart_addr    = 64'h0000_0000_0000_8004;
    localparam logic [addr_w-1:0] sd_addr_reg  = 64'h0000_0000_0000_8010;
    localparam logic [addr_w-1:0] sd_read_reg  = 64'h0000_0000_0000_8014;
    localparam logic [addr_w-1:0] sd_ready_reg = 64'h0000_0000_0000_8018;
    localparam logic [addr_w-1:0] sd_avail_reg = 64'h0000_0000_0000_801C;

    // Byte-wide SD sector window, 512-byte aligned
    localparam logic [addr_w-1:0] sd_buf_base = 64'h0000_0000_0000_9000;
    localparam logic [addr_w-1:0] sd_buf_size = 64'h0000_0000_0000_0200;

    // Status code the SD controller reports when it has gone idle
    localparam logic [4:0] sd_status_idle = 5'd6;

    // Decoded bus region
    typedef enum logic [3:0] {
        region_none,
        region_rom,
        region_ram,
        region_key,
        region_uart,
        region_sd_addr,
        region_sd_read,
        region_sd_ready,
        region_sd_avail,
        region_sd_buf
    } bus_region_e;

endpackage

`default_nettype wire

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  logic [soc_pkg::addr_w-1:0] bus_address,
    output soc_pkg::bus_region_e       region,
    output logic [11:0]                word_index,
    output logic [8:0]                 byte_index
);
    import soc_pkg::*;

    always_comb begin
        region = region_none;
        if (bus_address >= rom_base && bus_address < rom_base + rom_size) begin
            region = region_rom;
        end else if (bus_address >= ram_base && bus_address < ram_base + ram_size) begin
            region = region_ram;
        end else if (bus_address == key_addr) begin
            region = region_key;
        end else if (bus_address == uart_addr) begin
            region = region_uart;
        end else if (bus_address == sd_addr_reg) begin
            region = region_sd_addr;
        end else if (bus_address == sd_read_reg) begin
            region = region_sd_read;
        end else if (bus_address == sd_ready_reg) begin
            region = region_sd_ready;
        end else if (bus_address == sd_avail_reg) begin
            region = region_sd_avail;
        end else if (bus_address >= sd_buf_base && bus_address < sd_buf_base + sd_buf_size) begin
            region = region_sd_buf;
        end
    end

    // ROM and RAM both index the RAM by the full word address
    assign word_index = bus_address[13:2];
    // Buffer base is 512-aligned so the low bits are the offset
    assign byte_index = bus_address[8:0];

endmodule

`default_nettype wire

// ==== rtl/shared_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_ram (
    input  logic                       CLOCK_50,
    input  logic [soc_pkg::addr_w-1:0] fetch_addr,
    output logic [soc_pkg::word_w-1:0] instruction,
    input  logic [11:0]                word_index,
    input  logic                       write_enable,
    input  logic [soc_pkg::word_w-1:0] write_data,
    output logic [soc_pkg::word_w-1:0] read_word
);
    import soc_pkg::*;

    logic [word_w-1:0] mem [mem_words];
    logic [11:0]       fetch_index;
    logic [word_w-1:0] fetch_word;

    // Byte address to word index
    assign fetch_index = fetch_addr[13:2];
    assign fetch_word  = mem[fetch_index];

    // Port A, instruction fetch
    // Memory is little-endian, the core expects the bytes reversed
    always_ff @(posedge CLOCK_50) begin
        instruction <= {fetch_word[7:0], fetch_word[15:8],
                        fetch_word[23:16], fetch_word[31:24]};
    end

    // Port B, bus side
    always_ff @(posedge CLOCK_50) begin
        if (write_enable) begin
            mem[word_index] <= write_data;
        end
        // Read data lines up with the fabric's done pulse
        read_word <= mem[word_index];
    end

endmodule

`default_nettype wire

// ==== rtl/sd_sector_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_sector_buffer (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] sd_dout,
    input  logic       sd_byte_available,
    input  logic [4:0] sd_status,
    input  logic [8:0] byte_index,
    output logic [7:0] read_byte,
    output logic       sd_cache_available
);
    import soc_pkg::*;

    logic [7:0] sector [512];
    logic [8:0] fill_index;
    logic       strobe_d;
    logic       strobe_rise;
    // At least one byte of the current sector is stored
    logic       captured;

    assign strobe_rise = sd_byte_available && !strobe_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            strobe_d           <= 1'b0;
            fill_index         <= 9'd0;
            captured           <= 1'b0;
            sd_cache_available <= 1'b0;
        end else begin
            strobe_d <= sd_byte_available;
            if (strobe_rise) begin
                fill_index <= fill_index + 9'd1;
                captured   <= 1'b1;
                // New sector starting, old contents no longer valid
                if (fill_index == 9'd0) begin
                    sd_cache_available <= 1'b0;
                end
            end
            // Controller back to idle closes the sector
            if (captured && sd_status == sd_status_idle) begin
                fill_index         <= 9'd0;
                captured           <= 1'b0;
                sd_cache_available <= 1'b1;
            end
        end
    end

    // Byte storage
    always_ff @(posedge CLOCK_50) begin
        if (strobe_rise) begin
            sector[fill_index] <= sd_dout;
        end
    end

    // Bus read, one cycle latency
    always_ff @(posedge CLOCK_50) begin
        read_byte <= sector[byte_index];
    end

endmodule

`default_nettype wire

// ==== rtl/key_irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_pressed,
    input  logic [7:0] ascii,
    input  logic       irq_ack,
    output logic [7:0] key_char,
    output logic [3:0] irq_vector
);

    logic key_valid;
    logic ack_valid;

    // Decoder reports zero for keys with no character
    assign key_valid = key_pressed && (ascii != 8'd0);
    assign ack_valid = irq_ack && (irq_vector != 4'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_char   <= 8'd0;
            irq_vector <= 4'd0;
        end else begin
            if (key_valid) begin
                key_char <= ascii;
            end
            // Ack has priority over a new press
            if (ack_valid) begin
                irq_vector <= 4'd0;
            end else if (key_valid) begin
                irq_vector <= 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bus_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  soc_pkg::bus_region_e       region,
    input  logic                       bus_read_enable,
    input  logic                       bus_write_enable,
    input  logic [soc_pkg::data_w-1:0] bus_write_data,
    input  logic [soc_pkg::word_w-1:0] ram_word,
    input  logic [7:0]                 sd_byte,
    input  logic [7:0]                 key_char,
    input  logic                       sd_ready,
    input  logic                       sd_cache_available,
    output logic                       ram_write,
    output logic [soc_pkg::data_w-1:0] bus_read_data,
    output logic                       bus_read_done,
    output logic [31:0]                sd_addr,
    output logic                       sd_rd_start,
    output logic                       uart_write,
    output logic [31:0]                uart_data
);
    import soc_pkg::*;

    bus_region_e read_region;
    logic        uart_hit;
    logic        uart_hit_d;

    // Only the RAM window is writable, ROM writes are dropped
    assign ram_write = bus_write_enable && (region == region_ram);
    assign uart_hit  = bus_write_enable && (region == region_uart);

    // Read side
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_region   <= region_none;
            bus_read_done <= 1'b0;
        end else begin
            read_region   <= bus_read_enable ? region : region_none;
            // Every read gets a done, mapped or not
            bus_read_done <= bus_read_enable;
        end
    end

    // Sources are already one cycle late, matching read_region
    always_comb begin
        case (read_region)
            region_rom, region_ram: begin
                bus_read_data = {{(data_w-word_w){1'b0}}, ram_word};
            end
            region_key:      bus_read_data = {{(data_w-8){1'b0}}, key_char};
            region_sd_ready: bus_read_data = {{(data_w-1){1'b0}}, sd_ready};
            region_sd_avail: bus_read_data = {{(data_w-1){1'b0}}, sd_cache_available};
            region_sd_buf:   bus_read_data = {{(data_w-8){1'b0}}, sd_byte};
            default:         bus_read_data = '0;
        endcase
    end

    // SD control registers
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr     <= 32'd0;
            sd_rd_start <= 1'b0;
        end else begin
            if (bus_write_enable && region == region_sd_addr) begin
                sd_addr <= bus_write_data[31:0];
            end
            sd_rd_start <= bus_write_enable && (region == region_sd_read);
        end
    end

    // UART trigger, only the first of back-to-back writes fires
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_hit_d <= 1'b0;
            uart_write <= 1'b0;
        end else begin
            uart_hit_d <= uart_hit;
            uart_write <= uart_hit && !uart_hit_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_hit && !uart_hit_d) begin
            uart_data <= bus_write_data[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/board_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_bus_top (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  logic [soc_pkg::addr_w-1:0] fetch_addr,
    output logic [soc_pkg::word_w-1:0] instruction,
    input  logic [soc_pkg::addr_w-1:0] bus_address,
    input  logic [soc_pkg::data_w-1:0] bus_write_data,
    input  logic                       bus_read_enable,
    input  logic                       bus_write_enable,
    output logic [soc_pkg::data_w-1:0] bus_read_data,
    output logic                       bus_read_done,
    input  logic                       key_pressed,
    input  logic [7:0]                 ascii,
    input  logic                       irq_ack,
    output logic [3:0]                 irq_vector,
    input  logic [7:0]                 sd_dout,
    input  logic                       sd_byte_available,
    input  logic [4:0]                 sd_status,
    input  logic                       sd_ready,
    output logic [31:0]                sd_addr,
    output logic                       sd_rd_start,
    output logic                       uart_write,
    output logic [31:0]                uart_data,
    output logic                       sd_cache_available
);
    import soc_pkg::*;

    bus_region_e       region;
    logic [11:0]       word_index;
    logic [8:0]        byte_index;
    logic [word_w-1:0] ram_word;
    logic              ram_write;
    logic [7:0]        sd_byte;
    logic [7:0]        key_char;

    bus_decoder i_bus_decoder (
        .bus_address (bus_address),
        .region      (region),
        .word_index  (word_index),
        .byte_index  (byte_index)
    );

    shared_ram i_shared_ram (
        .CLOCK_50     (CLOCK_50),
        .fetch_addr   (fetch_addr),
        .instruction  (instruction),
        .word_index   (word_index),
        .write_enable (ram_write),
        .write_data   (bus_write_data[word_w-1:0]),
        .read_word    (ram_word)
    );

    sd_sector_buffer i_sd_sector_buffer (
        .CLOCK_50           (CLOCK_50),
        .KEY0               (KEY0),
        .sd_dout            (sd_dout),
        .sd_byte_available  (sd_byte_available),
        .sd_status          (sd_status),
        .byte_index         (byte_index),
        .read_byte          (sd_byte),
        .sd_cache_available (sd_cache_available)
    );

    key_irq_ctrl i_key_irq_ctrl (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_pressed (key_pressed),
        .ascii       (ascii),
        .irq_ack     (irq_ack),
        .key_char    (key_char),
        .irq_vector  (irq_vector)
    );

    bus_fabric i_bus_fabric (
        .CLOCK_50           (CLOCK_50),
        .KEY0               (KEY0),
        .region             (region),
        .bus_read_enable    (bus_read_enable),
        .bus_write_enable   (bus_write_enable),
        .bus_write_data     (bus_write_data),
        .ram_word           (ram_word),
        .sd_byte            (sd_byte),
        .key_char           (key_char),
        .sd_ready           (sd_ready),
        .sd_cache_available (sd_cache_available),
        .ram_write          (ram_write),
        .bus_read_data      (bus_read_data),
        .bus_read_done      (bus_read_done),
        .sd_addr            (sd_addr),
        .sd_rd_start        (sd_rd_start),
        .uart_write         (uart_write),
        .uart_data          (uart_data)
    );

endmodule

`default_nettype wire

// ==== tests/board_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_bus_checker (
    input logic       CLOCK_50,
    input logic       KEY0,
    input logic       bus_read_enable,
    input logic       bus_read_done,
    input logic       uart_write,
    input logic       sd_rd_start,
    input logic       irq_ack,
    input logic [3:0] irq_vector
);

    // Fixed one-cycle read latency
    read_done_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_done |-> $past(bus_read_enable))
    else $error("bus_read_done without bus_read_enable one cycle earlier");

    uart_single_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_write |=> !uart_write)
    else $error("uart_write high two cycles in a row");

    sd_read_single_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start)
    else $error("sd_rd_start high two cycles in a row");

    irq_ack_clears: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (irq_ack && irq_vector != 4'd0) |=> irq_vector == 4'd0)
    else $error("irq_vector not cleared after irq_ack");

endmodule

`default_nettype wire

// ==== tests/tb_board_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_bus;
    import soc_pkg::*;

    logic              CLOCK_50;
    logic              KEY0;
    logic [addr_w-1:0] fetch_addr;
    logic [word_w-1:0] instruction;
    logic [addr_w-1:0] bus_address;
    logic [data_w-1:0] bus_write_data;
    logic [data_w-1:0] bus_read_data;
    logic              bus_read_enable, bus_write_enable, bus_read_done;
    logic              key_pressed, irq_ack;
    logic [7:0]        ascii;
    logic [3:0]        irq_vector;
    logic [7:0]        sd_dout;
    logic              sd_byte_available, sd_ready, sd_rd_start, sd_cache_available;
    logic [4:0]        sd_status;
    logic [31:0]       sd_addr;
    logic              uart_write;
    logic [31:0]       uart_data;

    // One entry per pattern line, comments dropped
    logic [7:0]      op_q[$];
    logic [63:0]     arg_a_q[$];
    logic [63:0]     arg_b_q[$];
    logic [8*32-1:0] name_q[$];
    bit              loaded;

    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] uart_seen[$];
    int          uart_checked;
    int          rd_seen;
    int          rd_checked;
    // Expected interrupt vector, follows the set and ack rules
    logic [3:0]  irq_model;

    board_bus_top i_board_bus_top (.*);

    bind board_bus_top board_bus_checker i_board_bus_checker (
        .CLOCK_50        (CLOCK_50),
        .KEY0            (KEY0),
        .bus_read_enable (bus_read_enable),
        .bus_read_done   (bus_read_done),
        .uart_write      (uart_write),
        .sd_rd_start     (sd_rd_start),
        .irq_ack         (irq_ack),
        .irq_vector      (irq_vector)
    );

    always #20 CLOCK_50 = ~CLOCK_50;

    // UART and SD read pulses as the peripherals would see them
    always @(negedge CLOCK_50) begin
        if (KEY0 && uart_write) begin
            uart_seen.push_back(uart_data);
        end
        if (KEY0 && sd_rd_start) begin
            rd_seen++;
        end
    end

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic load_patterns(output bit ok);
        int              fd;
        int              code;
        int              nargs;
        bit              keep;
        logic [8*32-1:0] op;
        logic [8*32-1:0] name;
        logic [8*128-1:0] line;
        logic [63:0]     a;
        logic [63:0]     b;
        ok = 1'b0;
        fd = $fopen("tests/bus_patterns.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", op) == 1) begin
                a = '0;
                b = '0;
                name = '0;
                keep = 1'b1;
                nargs = 0;
                code = 0;
                case (op)
                    "#": begin
                        code = $fgets(line, fd);
                        keep = 1'b0;
                    end
                    "T": begin
                        nargs = 1;
                        code = $fscanf(fd, "%s", name);
                    end
                    "W", "R", "N", "F", "S", "D": begin
                        nargs = 2;
                        code = $fscanf(fd, "%h %h", a, b);
                    end
                    "K", "A", "U": begin
                        nargs = 1;
                        code = $fscanf(fd, "%h", a);
                    end
                    default: begin
                        $display("unknown opcode %0s in the pattern file", op);
                        keep = 1'b0;
                        ok = 1'b0;
                    end
                endcase
                if (keep && code != nargs) begin
                    $display("pattern line %0s is missing operands", op);
                    keep = 1'b0;
                    ok = 1'b0;
                end
                if (keep) begin
                    op_q.push_back(op[7:0]);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                    name_q.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_write_data   <= data;
        bus_write_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
    endtask

    task automatic bus_read(input logic [63:0] addr, output logic [63:0] data, output bit ok);
        int waited;
        @(posedge CLOCK_50);
        bus_address     <= addr;
        bus_read_enable <= 1'b1;
        // Done belongs to this cycle, so the CPU lets the level go here
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
        ok = 1'b0;
        data = '0;
        for (waited = 0; waited < 4 && !ok; waited++) begin
            @(negedge CLOCK_50);
            if (bus_read_done) begin
                ok = 1'b1;
                data = bus_read_data;
            end
        end
        if (!ok) begin
            $display("no bus_read_done within 4 cycles of a read at 0x%0h", addr);
            test_errors++;
        end else if (waited != 1) begin
            report_error($sformatf("read 0x%0h done after %0d cycles instead of one",
                                   addr, waited));
        end
    endtask

    task automatic check_fetch(input logic [63:0] addr, input logic [31:0] expected);
        @(posedge CLOCK_50);
        fetch_addr <= addr;
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        if (instruction !== expected) begin
            report_error($sformatf("fetch 0x%0h expected 0x%h got 0x%h",
                                   addr, expected, instruction));
        end
    endtask

    task automatic key_event(input logic [7:0] code, input bit press, input bit ack);
        @(posedge CLOCK_50);
        key_pressed <= press;
        ascii       <= code;
        irq_ack     <= ack;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        irq_ack     <= 1'b0;
        @(negedge CLOCK_50);
        if (irq_vector !== irq_model) begin
            report_error($sformatf("irq_vector expected %0d got %0d", irq_model, irq_vector));
        end
    endtask

    task automatic sd_burst(input int count, input logic [7:0] first);
        int         i;
        int         waited;
        logic [7:0] value;
        value = first;
        for (i = 0; i < count; i++) begin
            @(posedge CLOCK_50);
            sd_status         <= 5'd1;
            sd_ready          <= 1'b0;
            sd_dout           <= value;
            sd_byte_available <= 1'b1;
            @(posedge CLOCK_50);
            sd_byte_available <= 1'b0;
            value = value + 8'd1;
        end
        @(posedge CLOCK_50);
        sd_status <= sd_status_idle;
        sd_ready  <= 1'b1;
        waited = 0;
        do begin
            @(negedge CLOCK_50);
            waited++;
        end while (!sd_cache_available && waited < 4);
        if (!sd_cache_available) begin
            $display("sd_cache_available did not rise after the controller went idle");
            test_errors++;
        end
    endtask

    task automatic check_uart(input logic [31:0] expected);
        repeat (2) @(negedge CLOCK_50);
        // Clear of the monitor's sampling edges
        @(posedge CLOCK_50);
        if (uart_seen.size() - uart_checked != 1) begin
            report_error($sformatf("expected one uart_write pulse, saw %0d",
                                   uart_seen.size() - uart_checked));
        end else if (uart_seen[uart_checked] !== expected) begin
            report_error($sformatf("uart_data expected 0x%h got 0x%h",
                                   expected, uart_seen[uart_checked]));
        end
        uart_checked = uart_seen.size();
    endtask

    task automatic check_sd_regs(input logic [31:0] expected, input int pulses);
        repeat (2) @(negedge CLOCK_50);
        if (sd_addr !== expected) begin
            report_error($sformatf("sd_addr expected 0x%h got 0x%h", expected, sd_addr));
        end
        @(posedge CLOCK_50);
        if (rd_seen - rd_checked != pulses) begin
            report_error($sformatf("expected %0d sd_rd_start pulses, saw %0d",
                                   pulses, rd_seen - rd_checked));
        end
        rd_checked = rd_seen;
    endtask

    task automatic finish_test(input logic [8*32-1:0] name);
        if (test_errors == 0) begin
            $display("test %0s: passed", name);
            tests_passed++;
        end else begin
            $display("test %0s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        int              i;
        bit              ok;
        bit              in_test;
        logic [63:0]     a;
        logic [63:0]     b;
        logic [63:0]     got;
        logic [8*32-1:0] cur_name;
        CLOCK_50          = 1'b0;
        KEY0              = 1'b0;
        fetch_addr        = '0;
        bus_address       = '0;
        bus_write_data    = '0;
        bus_read_enable   = 1'b0;
        bus_write_enable  = 1'b0;
        key_pressed       = 1'b0;
        ascii             = 8'd0;
        irq_ack           = 1'b0;
        sd_dout           = 8'd0;
        sd_byte_available = 1'b0;
        sd_status         = 5'd0;
        sd_ready          = 1'b0;
        irq_model         = 4'd0;
        in_test           = 1'b0;
        load_patterns(ok);
        loaded = 1'b1;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        if (!ok) begin
            $display("pattern file tests/bus_patterns.txt could not be read");
            tests_failed++;
        end else begin
            for (i = 0; i < op_q.size(); i++) begin
                a = arg_a_q[i];
                b = arg_b_q[i];
                case (op_q[i])
                    "T": begin
                        if (in_test) begin
                            finish_test(cur_name);
                        end
                        cur_name = name_q[i];
                        in_test = 1'b1;
                        test_errors = 0;
                    end
                    "W": bus_write(a, b);
                    "R": begin
                        bus_read(a, got, ok);
                        if (ok && got !== b) begin
                            report_error($sformatf("read 0x%0h expected 0x%0h got 0x%0h",
                                                   a, b, got));
                        end
                    end
                    "N": begin
                        bus_read(a, got, ok);
                        if (ok && got === b) begin
                            report_error($sformatf("read 0x%0h returned the ignored 0x%0h",
                                                   a, b));
                        end
                    end
                    "F": check_fetch(a, b[31:0]);
                    "K": begin
                        if (a[7:0] != 8'd0) begin
                            irq_model = 4'd1;
                        end
                        key_event(a[7:0], 1'b1, 1'b0);
                    end
                    "A": begin
                        // Ack only counts against a pending vector
                        if (irq_model != 4'd0) begin
                            irq_model = 4'd0;
                        end else if (a[7:0] != 8'd0) begin
                            irq_model = 4'd1;
                        end
                        key_event(a[7:0], a[7:0] != 8'd0, 1'b1);
                    end
                    "S": sd_burst(int'(a[15:0]), b[7:0]);
                    "U": check_uart(a[31:0]);
                    "D": check_sd_regs(a[31:0], int'(b[7:0]));
                    default: report_error("unhandled pattern opcode");
                endcase
            end
            if (in_test) begin
                finish_test(cur_name);
            end
        end
        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, about 50 cycles for each pattern line
    initial begin
        wait (loaded);
        repeat (op_q.size() * 50) @(posedge CLOCK_50);
        $display("timeout: the run did not finish within %0d cycles", op_q.size() * 50);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/bus_patterns.txt ====
# op and hex operands: T name | W addr data | R addr expect | N addr ignored_data | F addr instr
# K ascii | A ascii_same_cycle | S count first_byte | U uart_data | D sd_addr sd_rd_start_pulses
T ram_rw
W 1000 aabbccdd12345678
R 1000 12345678
W 2ffc cafef00d
R 2ffc cafef00d
W 10 5a5a5a5a
N 10 5a5a5a5a
R 4000 0
R 8008 0
T fetch
F 1000 78563412
F 2ffc 0df0feca
T uart_sd_regs
W 8004 1122334455667788
U 55667788
W 8010 ffff000000000abc
W 8014 1
D abc 1
T sd_sector
R 801c 0
R 8018 0
S 10 a0
R 801c 1
R 8018 1
R 9000 a0
R 9001 a1
R 900f af
T key_irq
K 41
R 8000 41
A 0
K 0
R 8000 41
K 62
A 63
R 8000 63

// ==== vlog.f ====
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/shared_ram.sv
rtl/sd_sector_buffer.sv
rtl/key_irq_ctrl.sv
rtl/bus_fabric.sv
rtl/board_bus_top.sv
tests/board_bus_checker.sv
tests/tb_board_bus.sv

// ==== Bender.yml ====
package:
  name: board_bus

sources:
  - rtl/soc_pkg.sv
  - rtl/bus_decoder.sv
  - rtl/shared_ram.sv
  - rtl/sd_sector_buffer.sv
  - rtl/key_irq_ctrl.sv
  - rtl/bus_fabric.sv
  - rtl/board_bus_top.sv
  - target: test
    files:
      - tests/board_bus_checker.sv
      - tests/tb_board_bus.sv
